/* design/decode_pkg.sv */
`default_nettype none

package decode_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    ////////////////////////////////////////////////////////////
    // RV32I major opcodes
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // NOP sits at zero so a bubble is an all-zero bundle
    typedef enum logic [5:0] {
        NOP,
        LUI, ADD, SUB,
        SLL, SRL, SRA,
        SLT, SLTU,
        XOR, OR, AND,
        JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ECALL, EBREAK, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        INVALID
    } iop_e;

    typedef enum logic [2:0] {
        R_TYPE, I_TYPE, S_TYPE, B_TYPE, U_TYPE, J_TYPE
    } format_e;

    ////////////////////////////////////////////////////////////
    // Bundle toward execute
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        iop_e                  operation;
        logic [XLEN-1:0]       first_operand;
        logic [XLEN-1:0]       second_operand;
        logic [XLEN-1:0]       third_operand;
        logic [XLEN-1:0]       pc;
        logic [31:0]           instruction;
        logic [REG_ADDR_W-1:0] rd;
        logic                  exc_illegal;
        logic                  exc_misaligned;
    } ex_bundle_t;

    localparam ex_bundle_t EX_BUBBLE = '{
        operation:      NOP,
        first_operand:  '0,
        second_operand: '0,
        third_operand:  '0,
        pc:             '0,
        instruction:    '0,
        rd:             '0,
        exc_illegal:    1'b0,
        exc_misaligned: 1'b0
    };

endpackage

`default_nettype wire

/* design/op_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module op_decoder
    import decode_pkg::*;
(
    input  logic [31:0] instruction_i,
    output iop_e        operation_o,
    output format_e     format_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    iop_e       op_branch;
    iop_e       op_load;
    iop_e       op_store;
    iop_e       op_imm;
    iop_e       op_reg;
    iop_e       op_system;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];

    ////////////////////////////////////////////////////////////
    // Per-opcode operation tables
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (funct3)
            3'b000:  op_branch = BEQ;
            3'b001:  op_branch = BNE;
            3'b100:  op_branch = BLT;
            3'b101:  op_branch = BGE;
            3'b110:  op_branch = BLTU;
            3'b111:  op_branch = BGEU;
            default: op_branch = INVALID;
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  op_load = LB;
            3'b001:  op_load = LH;
            3'b010:  op_load = LW;
            3'b100:  op_load = LBU;
            3'b101:  op_load = LHU;
            default: op_load = INVALID;
        endcase
        case (funct3)
            3'b000:  op_store = SB;
            3'b001:  op_store = SH;
            3'b010:  op_store = SW;
            default: op_store = INVALID;
        endcase
    end

    // Only the shift immediates care about funct7
    always_comb begin
        case (funct3)
            3'b000:  op_imm = ADD;
            3'b001:  op_imm = (funct7 == 7'b0000000) ? SLL : INVALID;
            3'b010:  op_imm = SLT;
            3'b011:  op_imm = SLTU;
            3'b100:  op_imm = XOR;
            3'b101:  op_imm = (funct7 == 7'b0000000) ? SRL :
                              (funct7 == 7'b0100000) ? SRA : INVALID;
            3'b110:  op_imm = OR;
            default: op_imm = AND;
        endcase
    end

    // M extension encodings land in default
    always_comb begin
        case ({funct7, funct3})
            10'b0000000_000: op_reg = ADD;
            10'b0100000_000: op_reg = SUB;
            10'b0000000_001: op_reg = SLL;
            10'b0000000_010: op_reg = SLT;
            10'b0000000_011: op_reg = SLTU;
            10'b0000000_100: op_reg = XOR;
            10'b0000000_101: op_reg = SRL;
            10'b0100000_101: op_reg = SRA;
            10'b0000000_110: op_reg = OR;
            10'b0000000_111: op_reg = AND;
            default:         op_reg = INVALID;
        endcase
    end

    // Privileged ops need every other field zero
    always_comb begin
        case (funct3)
            3'b000: begin
                case ({instruction_i[31:15], instruction_i[11:7]})
                    {12'h000, 10'd0}: op_system = ECALL;
                    {12'h001, 10'd0}: op_system = EBREAK;
                    {12'h302, 10'd0}: op_system = MRET;
                    {12'h105, 10'd0}: op_system = WFI;
                    default:          op_system = INVALID;
                endcase
            end
            3'b001:  op_system = CSRRW;
            3'b010:  op_system = CSRRS;
            3'b011:  op_system = CSRRC;
            3'b101:  op_system = CSRRWI;
            3'b110:  op_system = CSRRSI;
            3'b111:  op_system = CSRRCI;
            default: op_system = INVALID;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Opcode select and format
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (opcode)
            OPC_LUI:      operation_o = LUI;
            OPC_AUIPC:    operation_o = ADD;
            OPC_JAL:      operation_o = JAL;
            OPC_JALR:     operation_o = JALR;
            OPC_BRANCH:   operation_o = op_branch;
            OPC_LOAD:     operation_o = op_load;
            OPC_STORE:    operation_o = op_store;
            OPC_OP_IMM:   operation_o = op_imm;
            OPC_OP:       operation_o = op_reg;
            OPC_MISC_MEM: operation_o = (funct3 == 3'b000) ? NOP : INVALID;
            OPC_SYSTEM:   operation_o = op_system;
            default:      operation_o = INVALID;
        endcase
    end

    always_comb begin
        case (opcode[6:2])
            OPC_JALR[6:2], OPC_LOAD[6:2], OPC_OP_IMM[6:2]: format_o = I_TYPE;
            OPC_STORE[6:2]:                                format_o = S_TYPE;
            OPC_BRANCH[6:2]:                               format_o = B_TYPE;
            OPC_LUI[6:2], OPC_AUIPC[6:2]:                  format_o = U_TYPE;
            OPC_JAL[6:2]:                                  format_o = J_TYPE;
            default:                                       format_o = R_TYPE;
        endcase
        // Operation tables and format table must agree
        a_format_matches_op: assert (
            (!(operation_o inside {BEQ, BNE, BLT, BGE, BLTU, BGEU}) || format_o == B_TYPE) &&
            (!(operation_o inside {LB, LH, LW, LBU, LHU}) || format_o == I_TYPE) &&
            (!(operation_o inside {SB, SH, SW}) || format_o == S_TYPE));
    end

endmodule

`default_nettype wire

/* design/imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  logic [31:0]     instruction_i,
    input  format_e         format_i,
    output logic [XLEN-1:0] imm_o
);

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_u;
    logic [XLEN-1:0] imm_j;

    // Bit 31 always carries the sign
    assign imm_i = {{21{instruction_i[31]}}, instruction_i[30:20]};
    assign imm_s = {{21{instruction_i[31]}}, instruction_i[30:25], instruction_i[11:7]};
    assign imm_b = {{20{instruction_i[31]}}, instruction_i[7],
                    instruction_i[30:25], instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    always_comb begin
        case (format_i)
            I_TYPE:  imm_o = imm_i;
            S_TYPE:  imm_o = imm_s;
            B_TYPE:  imm_o = imm_b;
            U_TYPE:  imm_o = imm_u;
            J_TYPE:  imm_o = imm_j;
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module hazard_unit
    import decode_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        enable_i,
    input  logic [31:0] instruction_i,
    input  format_e     format_i,
    input  logic        jumping_i,
    input  logic        rollback_i,
    output logic        hazard_o,
    output logic        killed_o,
    output logic        bubble_o
);

    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] locked_reg;
    logic                  locked_mem;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  is_mem;
    logic                  is_store;
    logic                  hazard_reg;
    logic                  kill;

    assign rs1      = instruction_i[19:15];
    assign rs2      = instruction_i[24:20];
    assign rd       = instruction_i[11:7];
    assign is_store = instruction_i[6:0] == OPC_STORE;
    assign is_mem   = is_store || instruction_i[6:0] == OPC_LOAD;

    always_comb begin
        case (format_i)
            R_TYPE, B_TYPE, S_TYPE: {use_rs1, use_rs2} = 2'b11;
            I_TYPE:                 {use_rs1, use_rs2} = 2'b10;
            default:                {use_rs1, use_rs2} = 2'b00;
        endcase
    end

    // x0 is never locked
    assign hazard_reg = locked_reg != '0 &&
                        ((use_rs1 && locked_reg == rs1) || (use_rs2 && locked_reg == rs2));

    assign kill     = jumping_i || rollback_i;
    assign hazard_o = (hazard_reg || (locked_mem && is_mem)) && !kill;
    assign bubble_o = hazard_o || kill;

    ////////////////////////////////////////////////////////////
    // Lock of the last issued instruction
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_reg <= '0;
            locked_mem <= 1'b0;
            killed_o   <= 1'b0;
        end else if (enable_i) begin
            locked_reg <= bubble_o ? '0 : rd;
            locked_mem <= !bubble_o && is_store;
            killed_o   <= kill;
        end
    end

    // Empty lock right after a bubble, so nothing can stall
    a_no_hazard_after_bubble: assert property (@(posedge clk) disable iff (!reset_n)
        enable_i && bubble_o |=> !hazard_o);

    a_bubble_clears_lock: assert property (@(posedge clk) disable iff (!reset_n)
        enable_i && bubble_o |=> locked_reg == '0 && !locked_mem);

endmodule

`default_nettype wire

/* design/decode_stage.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  enable_i,
    input  logic [31:0]           instruction_i,
    input  logic [XLEN-1:0]       pc_i,
    input  logic [XLEN-1:0]       rs1_data_i,
    input  logic [XLEN-1:0]       rs2_data_i,
    input  logic                  jumping_i,
    input  logic                  rollback_i,
    output logic [REG_ADDR_W-1:0] rs1_o,
    output logic [REG_ADDR_W-1:0] rs2_o,
    output logic                  hazard_o,
    output logic                  killed_o,
    output ex_bundle_t            ex_o
);

    iop_e            operation;
    format_e         instr_format;
    logic [XLEN-1:0] immediate;
    logic            bubble;
    ex_bundle_t      ex_next;

    op_decoder u_op_decoder (
        .instruction_i (instruction_i),
        .operation_o   (operation),
        .format_o      (instr_format)
    );

    imm_gen u_imm_gen (
        .instruction_i (instruction_i),
        .format_i      (instr_format),
        .imm_o         (immediate)
    );

    hazard_unit u_hazard_unit (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable_i),
        .instruction_i (instruction_i),
        .format_i      (instr_format),
        .jumping_i     (jumping_i),
        .rollback_i    (rollback_i),
        .hazard_o      (hazard_o),
        .killed_o      (killed_o),
        .bubble_o      (bubble)
    );

    // Register bank is read in the same cycle
    assign rs1_o = instruction_i[19:15];
    assign rs2_o = instruction_i[24:20];

    ////////////////////////////////////////////////////////////
    // Operands and exception flags
    ////////////////////////////////////////////////////////////

    always_comb begin
        ex_next.operation   = operation;
        ex_next.pc          = pc_i;
        ex_next.instruction = instruction_i;
        ex_next.rd          = instruction_i[11:7];

        // LUI/AUIPC/JAL work from the pc
        ex_next.first_operand = (instr_format inside {U_TYPE, J_TYPE}) ? pc_i : rs1_data_i;
        ex_next.second_operand = (instr_format inside {R_TYPE, B_TYPE}) ? rs2_data_i
                                                                        : immediate;
        // Store data rides in the third operand
        ex_next.third_operand = (instr_format == S_TYPE) ? rs2_data_i : immediate;

        ex_next.exc_illegal    = operation == INVALID;
        ex_next.exc_misaligned = pc_i[1:0] != 2'b00;
    end

    ////////////////////////////////////////////////////////////
    // Register toward execute
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ex_o <= EX_BUBBLE;
        end else if (enable_i) begin
            ex_o <= bubble ? EX_BUBBLE : ex_next;
        end
    end

    a_illegal_flag: assert property (@(posedge clk) disable iff (!reset_n)
        ex_o.exc_illegal == (ex_o.operation == INVALID));

endmodule

`default_nettype wire

/* sim/decode_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_tb
    import decode_pkg::*;
();

    localparam int CHECK_W     = $bits(ex_bundle_t);
    localparam int NUM_LEGAL   = 17;
    localparam int DRAIN_LIMIT = 50;

    // Instruction template with the operation and format it must decode to
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic       fix_funct3;
        logic [6:0] funct7;
        logic       fix_funct7;
        iop_e       operation;
        format_e    fmt;
    } template_t;

    typedef struct packed {
        logic                  enable;
        logic                  hazard;
        logic                  killed;
        logic [REG_ADDR_W-1:0] src1;
        logic [REG_ADDR_W-1:0] src2;
        ex_bundle_t            ex;
    } expect_t;

    logic                  clk;
    logic                  reset_n;
    logic                  enable;
    logic                  jumping;
    logic                  rollback;
    logic [31:0]           instruction;
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       rs1_data;
    logic [XLEN-1:0]       rs2_data;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic                  hazard;
    logic                  killed;
    ex_bundle_t            ex;

    logic [31:0]           seed;
    logic [REG_ADDR_W-1:0] lock_reg;
    logic                  lock_mem;
    expect_t               pending[$];
    ex_bundle_t            held_ex;
    logic                  held_killed;
    logic                  timed_out;
    int                    checks;
    int                    errors;
    int                    compares;
    int                    test_checks;
    int                    test_errors;

    decode_stage u_decode_stage (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable),
        .instruction_i (instruction),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .jumping_i     (jumping),
        .rollback_i    (rollback),
        .rs1_o         (rs1),
        .rs2_o         (rs2),
        .hazard_o      (hazard),
        .killed_o      (killed),
        .ex_o          (ex)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Register bank answers with a fixed pattern per address
    function automatic logic [XLEN-1:0] bank_value(input logic [REG_ADDR_W-1:0] addr);
        return (addr == '0) ? '0 : {addr, ~addr, 22'h15a5a5};
    endfunction

    assign rs1_data = bank_value(rs1);
    assign rs2_data = bank_value(rs2);

    function automatic logic [31:0] next_random();
        logic [31:0] s;
        s = seed;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        seed = s;
        return s;
    endfunction

    function automatic logic [31:0] aligned_pc();
        logic [31:0] p;
        p = next_random();
        return {p[31:2], 2'b00};
    endfunction

    //////////////////////////////////////////////////////////////
    // Instruction templates, legal ones first
    //////////////////////////////////////////////////////////////

    function automatic template_t pick_template(input int idx);
        case (idx)
            0:  return '{OPC_LUI,    3'd0, 1'b0, 7'h00, 1'b0, LUI,   U_TYPE};
            1:  return '{OPC_AUIPC,  3'd0, 1'b0, 7'h00, 1'b0, ADD,   U_TYPE};
            2:  return '{OPC_JAL,    3'd0, 1'b0, 7'h00, 1'b0, JAL,   J_TYPE};
            3:  return '{OPC_JALR,   3'd0, 1'b1, 7'h00, 1'b0, JALR,  I_TYPE};
            4:  return '{OPC_BRANCH, 3'd0, 1'b1, 7'h00, 1'b0, BEQ,   B_TYPE};
            5:  return '{OPC_BRANCH, 3'd6, 1'b1, 7'h00, 1'b0, BLTU,  B_TYPE};
            6:  return '{OPC_LOAD,   3'd2, 1'b1, 7'h00, 1'b0, LW,    I_TYPE};
            7:  return '{OPC_LOAD,   3'd4, 1'b1, 7'h00, 1'b0, LBU,   I_TYPE};
            8:  return '{OPC_STORE,  3'd2, 1'b1, 7'h00, 1'b0, SW,    S_TYPE};
            9:  return '{OPC_STORE,  3'd0, 1'b1, 7'h00, 1'b0, SB,    S_TYPE};
            10: return '{OPC_OP_IMM, 3'd0, 1'b1, 7'h00, 1'b0, ADD,   I_TYPE};
            11: return '{OPC_OP_IMM, 3'd4, 1'b1, 7'h00, 1'b0, XOR,   I_TYPE};
            12: return '{OPC_OP_IMM, 3'd5, 1'b1, 7'h20, 1'b1, SRA,   I_TYPE};
            13: return '{OPC_OP,     3'd0, 1'b1, 7'h00, 1'b1, ADD,   R_TYPE};
            14: return '{OPC_OP,     3'd0, 1'b1, 7'h20, 1'b1, SUB,   R_TYPE};
            15: return '{OPC_OP,     3'd7, 1'b1, 7'h00, 1'b1, AND,   R_TYPE};
            16: return '{OPC_SYSTEM, 3'd2, 1'b1, 7'h00, 1'b0, CSRRS, R_TYPE};
            // MUL encoding
            17: return '{OPC_OP,     3'd0, 1'b1, 7'h01, 1'b1, INVALID, R_TYPE};
            default: return '{7'b0000111, 3'd0, 1'b0, 7'h00, 1'b0, INVALID, R_TYPE};
        endcase
    endfunction

    function automatic logic [31:0] build_instr(input template_t t,
                                                input logic [4:0] rs1_sel,
                                                input logic [4:0] rs2_sel,
                                                input logic [4:0] rd_sel);
        logic [31:0] word;
        word = next_random();
        word[6:0]   = t.opcode;
        word[11:7]  = rd_sel;
        word[19:15] = rs1_sel;
        word[24:20] = rs2_sel;
        if (t.fix_funct3)
            word[14:12] = t.funct3;
        if (t.fix_funct7)
            word[31:25] = t.funct7;
        return word;
    endfunction

    //////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////

    function automatic logic [31:0] expected_imm(input logic [31:0] w, input format_e fmt);
        case (fmt)
            I_TYPE:  return $signed(w) >>> 20;
            S_TYPE:  return {{20{w[31]}}, w[31:25], w[11:7]};
            B_TYPE:  return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            U_TYPE:  return {w[31:12], 12'h000};
            J_TYPE:  return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'h0;
        endcase
    endfunction

    function automatic ex_bundle_t expect_result(input logic [31:0] w,
                                                 input iop_e op,
                                                 input format_e fmt,
                                                 input logic [31:0] pc_val,
                                                 input logic kill,
                                                 output logic haz);
        ex_bundle_t  result;
        logic        uses_rs1;
        logic        uses_rs2;
        logic        mem_access;
        logic [31:0] imm;
        uses_rs1   = !(fmt == U_TYPE || fmt == J_TYPE);
        uses_rs2   = fmt == R_TYPE || fmt == S_TYPE || fmt == B_TYPE;
        mem_access = w[6:0] == OPC_LOAD || w[6:0] == OPC_STORE;
        haz = !kill && ((lock_reg != 5'd0 && ((uses_rs1 && lock_reg == w[19:15]) ||
                                              (uses_rs2 && lock_reg == w[24:20]))) ||
                        (lock_mem && mem_access));
        imm = expected_imm(w, fmt);
        result.operation      = op;
        result.first_operand  = uses_rs1 ? bank_value(w[19:15]) : pc_val;
        result.second_operand = (fmt == R_TYPE || fmt == B_TYPE) ? bank_value(w[24:20]) : imm;
        result.third_operand  = (fmt == S_TYPE) ? bank_value(w[24:20]) : imm;
        result.pc             = pc_val;
        result.instruction    = w;
        result.rd             = w[11:7];
        result.exc_illegal    = op == INVALID;
        result.exc_misaligned = pc_val[1:0] != 2'b00;
        if (haz || kill)
            result = EX_BUBBLE;
        return result;
    endfunction

    task automatic drive_cycle(input logic [31:0] w, input template_t t,
                               input logic [31:0] pc_val, input logic en,
                               input logic jump, input logic rb);
        expect_t item;
        logic    haz;
        @(negedge clk);
        instruction = w;
        pc          = pc_val;
        enable      = en;
        jumping     = jump;
        rollback    = rb;
        item.enable = en;
        item.killed = jump || rb;
        item.src1   = w[19:15];
        item.src2   = w[24:20];
        item.ex     = expect_result(w, t.operation, t.fmt, pc_val, jump || rb, haz);
        item.hazard = haz;
        pending.push_back(item);
        // Lock follows the stage only on enabled cycles
        if (en) begin
            if (haz || jump || rb) begin
                lock_reg = '0;
                lock_mem = 1'b0;
            end else begin
                lock_reg = w[11:7];
                lock_mem = w[6:0] == OPC_STORE;
            end
        end
    endtask

    //////////////////////////////////////////////////////////////
    // Comparator
    //////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [CHECK_W-1:0] actual,
                               input logic [CHECK_W-1:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL time=%0t signal=%s got=%h exp=%h", $time, name, actual, expected);
        end
    endtask

    always @(posedge clk) begin
        expect_t item;
        if (reset_n) begin
            check_value("ex_o", ex, held_ex);
            check_value("killed_o", killed, held_killed);
            if (pending.size() > 0) begin
                item = pending.pop_front();
                check_value("hazard_o", hazard, item.hazard);
                check_value("rs1_o", rs1, item.src1);
                check_value("rs2_o", rs2, item.src2);
                if (item.enable) begin
                    held_ex     = item.ex;
                    held_killed = item.killed;
                end
            end
            compares++;
        end
    end

    task automatic finish_test(input string name);
        int waited;
        int start;
        @(negedge clk);
        enable   = 1'b0;
        jumping  = 1'b0;
        rollback = 1'b0;
        waited   = 0;
        while (pending.size() != 0 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        start = compares;
        while (compares < start + 1 && waited < DRAIN_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= DRAIN_LIMIT) begin
            timed_out = 1'b1;
            $display("%s: timed out waiting for the comparator to drain", name);
        end
        $display("%s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    //////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////

    task automatic test_decode();
        template_t   t;
        logic [31:0] r;
        repeat (60) begin
            t = pick_template(next_random() % NUM_LEGAL);
            r = next_random();
            // Sources below x16, destinations above, so no dependencies
            drive_cycle(build_instr(t, {1'b0, r[3:0]}, {1'b0, r[7:4]}, {1'b1, r[11:8]}),
                        t, aligned_pc(), r[15:13] != 3'd0, 1'b0, 1'b0);
        end
    endtask

    task automatic test_illegal();
        template_t   t;
        logic [31:0] r;
        for (int i = 0; i < 10; i++) begin
            t = pick_template(17 + (i % 2));
            r = next_random();
            drive_cycle(build_instr(t, {1'b0, r[3:0]}, {1'b0, r[7:4]}, {1'b1, r[11:8]}),
                        t, aligned_pc(), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic test_misaligned();
        template_t   t;
        logic [31:0] r;
        logic [31:0] p;
        for (int i = 0; i < 12; i++) begin
            t = pick_template(next_random() % NUM_LEGAL);
            r = next_random();
            p = aligned_pc();
            p[1:0] = i[1:0];
            drive_cycle(build_instr(t, r[4:0], r[9:5], r[14:10]), t, p, 1'b1,
                        r[18:16] == 3'd0, 1'b0);
        end
    endtask

    task automatic test_hazards();
        template_t   t;
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0]  dst;
        int          consumers[4] = '{13, 10, 8, 4};
        for (int i = 0; i < 8; i++) begin
            r   = next_random();
            dst = (i == 7) ? 5'd0 : {r[4:1], 1'b1};
            drive_cycle(build_instr(pick_template(13), 5'd1, 5'd2, dst), pick_template(13),
                        aligned_pc(), 1'b1, 1'b0, 1'b0);
            t = pick_template(consumers[i % 4]);
            w = i[0] ? build_instr(t, 5'd3, dst, 5'd20) : build_instr(t, dst, 5'd3, 5'd20);
            drive_cycle(w, t, aligned_pc(), 1'b1, 1'b0, 1'b0);
            drive_cycle(w, t, aligned_pc(), 1'b1, 1'b0, 1'b0);
        end
        // Memory access right behind a store
        for (int i = 0; i < 3; i++) begin
            t = pick_template(8);
            drive_cycle(build_instr(t, 5'd4, 5'd5, 5'd0), t, aligned_pc(), 1'b1, 1'b0, 1'b0);
            t = pick_template(i == 2 ? 9 : 6 + i);
            w = build_instr(t, 5'd4, 5'd5, 5'd21);
            drive_cycle(w, t, aligned_pc(), 1'b1, 1'b0, 1'b0);
            drive_cycle(w, t, aligned_pc(), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic test_kill();
        template_t   t;
        logic [31:0] r;
        logic [31:0] w;
        logic [4:0]  dst;
        t = pick_template(13);
        for (int i = 0; i < 6; i++) begin
            r   = next_random();
            dst = {r[4:1], 1'b1};
            drive_cycle(build_instr(t, 5'd1, 5'd2, dst), t, aligned_pc(), 1'b1, 1'b0, 1'b0);
            w = build_instr(t, dst, 5'd6, 5'd22);
            drive_cycle(w, t, aligned_pc(), 1'b1, i[0], !i[0]);
            drive_cycle(w, t, aligned_pc(), 1'b1, 1'b0, 1'b0);
        end
    endtask

    task automatic test_stall();
        template_t   t;
        logic [31:0] r;
        for (int i = 0; i < 4; i++) begin
            t = pick_template(next_random() % NUM_LEGAL);
            r = next_random();
            drive_cycle(build_instr(t, r[4:0], r[9:5], r[14:10]), t, aligned_pc(), 1'b1,
                        i[0], 1'b0);
            repeat (6) begin
                t = pick_template(next_random() % NUM_LEGAL);
                r = next_random();
                drive_cycle(build_instr(t, r[4:0], r[9:5], r[14:10]), t, next_random(),
                            1'b0, r[15], r[16]);
            end
        end
    endtask

    task automatic run_test(input int num);
        case (num)
            1: begin test_decode();     finish_test("decode and operands");  end
            2: begin test_illegal();    finish_test("illegal instructions"); end
            3: begin test_misaligned(); finish_test("misaligned fetch");     end
            4: begin test_hazards();    finish_test("hazards");              end
            5: begin test_kill();       finish_test("kill");                 end
            default: begin test_stall(); finish_test("stall");               end
        endcase
    endtask

    initial begin
        seed        = 32'h1d0e_e706;
        reset_n     = 1'b0;
        enable      = 1'b0;
        jumping     = 1'b0;
        rollback    = 1'b0;
        instruction = '0;
        pc          = '0;
        lock_reg    = '0;
        lock_mem    = 1'b0;
        held_ex     = EX_BUBBLE;
        held_killed = 1'b0;
        timed_out   = 1'b0;
        checks      = 0;
        errors      = 0;
        compares    = 0;
        test_checks = 0;
        test_errors = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int num = 1; num <= 6 && !timed_out; num++)
            run_test(num);
        $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/decode_pkg.sv
design/op_decoder.sv
design/imm_gen.sv
design/hazard_unit.sv
design/decode_stage.sv
sim/decode_tb.sv

/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = decode_tb
RTL_TOP    = decode_stage
FILELIST   = src.f
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAILED" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
